// File: dv/utim_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "utim_defines.svh"

module utim_tb;

	import utim_reg_pkg::*;
	import utim_timer_pkg::*;

	// About twice the 1900 timer cycles that all tests take
	localparam int TIMEOUT_CYCLES = 4000;
	// Timer cycles from the start request to the counter start edge
	localparam int START_WINDOW = 16;

	logic iIF_CLOCK;
	logic iTIMER_CLOCK;
	logic inRESET;
	logic req_valid;
	logic req_busy;
	logic req_rw;
	reg_addr_t req_addr;
	reg_word_t req_data;
	logic resp_valid;
	reg_word_t resp_data;
	chan_mask_t irq;

	reg_word_t shadow [`UTIM_REG_COUNT];
	reg_word_t exp_resp[$];
	reg_word_t got_resp[$];
	reg_word_t cmp_got;
	reg_word_t cmp_want;
	int irq_cycle[$];
	int irq_chan[$];
	int exp_irq[$];

	int tcycle;
	int last_issue;
	int errors;
	int err_at_start;
	int tests_passed;
	int tests_failed;
	int issue;

	utim_top i_dut (
		.iIF_CLOCK(iIF_CLOCK),
		.iTIMER_CLOCK(iTIMER_CLOCK),
		.inRESET(inRESET),
		.req_valid(req_valid),
		.req_busy(req_busy),
		.req_rw(req_rw),
		.req_addr(req_addr),
		.req_data(req_data),
		.resp_valid(resp_valid),
		.resp_data(resp_data),
		.irq(irq)
	);

	always #4 iTIMER_CLOCK = ~iTIMER_CLOCK;
	always #6 iIF_CLOCK = ~iIF_CLOCK;

	always @(posedge iTIMER_CLOCK) begin
		tcycle <= tcycle + 1;
		if (tcycle >= TIMEOUT_CYCLES) begin
			$display("Run stopped: timer cycle limit of %0d reached", TIMEOUT_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	// Monitors sample between the edges that move the outputs
	always @(negedge iIF_CLOCK) begin
		if (inRESET && resp_valid) begin
			got_resp.push_back(resp_data);
		end
	end

	always @(negedge iTIMER_CLOCK) begin
		if (inRESET) begin
			for (int c = 0; c < `UTIM_CHANNELS; c++) begin
				if (irq[c]) begin
					irq_cycle.push_back(tcycle);
					irq_chan.push_back(c);
				end
			end
		end
	end

	// Response checker
	always @(posedge iIF_CLOCK) begin
		while (got_resp.size() > 0) begin
			cmp_got = got_resp.pop_front();
			assert (exp_resp.size() != 0) else begin
				$display("A response arrived at %0t ns with no read outstanding", $time);
				errors++;
			end
			if (exp_resp.size() != 0) begin
				cmp_want = exp_resp.pop_front();
				assert (cmp_got == cmp_want) else begin
					$display("[ERROR] %0t ns: resp_data expected %08h, got %08h",
						$time, cmp_want, cmp_got);
					errors++;
				end
			end
		end
	end

	// Pulse offsets counted from the edge where the counter starts
	function automatic void expect_irq_times(input count_t start, input count_t target,
		input count_t period, input bit periodic, input bit irq_en, input bit mode64,
		input bit running, input int horizon);
		count_t value;
		count_t tgt;
		bit en;
		bit hit;
		exp_irq.delete();
		value = start;
		tgt = target;
		en = 1'b1;
		for (int k = 0; k < horizon; k++) begin
			hit = mode64 ? (value == tgt) : (value[31:0] == tgt[31:0]);
			if (en && running && hit) begin
				if (irq_en) begin
					exp_irq.push_back(k + 1);
				end
				if (periodic) begin
					tgt = tgt + period;
				end else begin
					en = 1'b0;
				end
			end
			if (running) begin
				value = value + 64'd1;
			end
		end
	endfunction

	task automatic host_request(input logic rw, input reg_addr_t addr, input reg_word_t data);
		@(posedge iIF_CLOCK);
		req_valid <= 1'b1;
		req_rw <= rw;
		req_addr <= addr;
		req_data <= data;
		last_issue = tcycle;
		// Hold the request until the FIFO has room
		@(negedge iIF_CLOCK);
		while (req_busy) begin
			@(negedge iIF_CLOCK);
		end
	endtask

	task automatic host_idle();
		@(posedge iIF_CLOCK);
		req_valid <= 1'b0;
	endtask

	task automatic write_reg(input int addr, input reg_word_t data);
		shadow[addr] = data;
		host_request(1'b1, reg_addr_t'(addr), data);
	endtask

	task automatic read_reg(input int addr);
		exp_resp.push_back(shadow[addr]);
		host_request(1'b0, reg_addr_t'(addr), '0);
	endtask

	task automatic drain();
		host_idle();
		while (exp_resp.size() != 0) begin
			@(negedge iIF_CLOCK);
		end
	endtask

	task automatic quiet_and_load(input count_t start);
		write_reg(`UTIM_MAIN_CFG, 32'd0);
		for (int c = 0; c < `UTIM_CHANNELS; c++) begin
			write_reg(`UTIM_CMP_CFG_BASE + c, 32'd0);
		end
		write_reg(`UTIM_MAIN_HI, start[63:32]);
		write_reg(`UTIM_MAIN_LO, start[31:0]);
	endtask

	task automatic set_channel(input int ch, input count_t tgt, input reg_word_t cfg);
		write_reg(`UTIM_CMP_HI_BASE + 2 * ch, tgt[63:32]);
		write_reg(`UTIM_CMP_LO_BASE + 2 * ch, tgt[31:0]);
		write_reg(`UTIM_CMP_CFG_BASE + ch, cfg);
	endtask

	// Read back and wait until every earlier write has landed
	task automatic sync_point();
		read_reg(`UTIM_MAIN_CFG);
		drain();
		irq_cycle.delete();
		irq_chan.delete();
	endtask

	task automatic start_counter();
		write_reg(`UTIM_MAIN_CFG, 32'd1);
		issue = last_issue;
		host_idle();
	endtask

	task automatic observe(input int span);
		while (tcycle < issue + span) begin
			@(posedge iIF_CLOCK);
		end
	endtask

	task automatic check_irq(input int ch);
		int n;
		int shift;
		n = 0;
		shift = 0;
		for (int i = 0; i < irq_cycle.size(); i++) begin
			if (irq_chan[i] == ch) begin
				if (n == 0 && exp_irq.size() > 0) begin
					shift = irq_cycle[i] - exp_irq[0];
					assert (shift - issue >= 1 && shift - issue <= START_WINDOW) else begin
						$display("irq[%0d] first pulse at cycle %0d is too far from the start request",
							ch, irq_cycle[i]);
						errors++;
					end
				end
				if (n < exp_irq.size()) begin
					assert (irq_cycle[i] == exp_irq[n] + shift) else begin
						$display("[ERROR] %0t ns: irq[%0d] pulse cycle expected %0d, got %0d",
							$time, ch, exp_irq[n] + shift, irq_cycle[i]);
						errors++;
					end
				end
				n++;
			end
		end
		assert (n == exp_irq.size()) else begin
			$display("[ERROR] %0t ns: irq[%0d] pulse count expected %0d, got %0d",
				$time, ch, exp_irq.size(), n);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == err_at_start) begin
			tests_passed++;
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: FAIL with %0d errors", name, errors - err_at_start);
		end
		err_at_start = errors;
	endtask

	initial begin
		iIF_CLOCK = 1'b0;
		iTIMER_CLOCK = 1'b0;
		inRESET = 1'b0;
		req_valid = 1'b0;
		req_rw = 1'b0;
		req_addr = '0;
		req_data = '0;
		tcycle = 0;
		errors = 0;
		err_at_start = 0;
		tests_passed = 0;
		tests_failed = 0;
		issue = 0;
		last_issue = 0;
		void'($urandom(34974));
		for (int a = 0; a < `UTIM_REG_COUNT; a++) begin
			shadow[a] = '0;
		end
		repeat (8) @(posedge iTIMER_CLOCK);
		inRESET <= 1'b1;

		// Idle outputs and then zero reads from every register
		repeat (20) begin
			@(negedge iIF_CLOCK);
			assert (req_busy == 1'b0 && resp_valid == 1'b0 && irq == '0) else begin
				$display("[ERROR] %0t ns: req_busy/resp_valid/irq expected 0/0/0, got %0b/%0b/%0h",
					$time, req_busy, resp_valid, irq);
				errors++;
			end
		end
		for (int a = 0; a < `UTIM_REG_COUNT; a++) begin
			read_reg(a);
		end
		drain();
		end_test("Test 1 reset state");

		for (int a = 0; a < `UTIM_REG_COUNT; a++) begin
			write_reg(a, $urandom());
		end
		// Two passes of back-to-back reads
		for (int a = 0; a < 2 * `UTIM_REG_COUNT; a++) begin
			read_reg(a % `UTIM_REG_COUNT);
		end
		drain();
		end_test("Test 2 register write and read");

		quiet_and_load(64'd0);
		set_channel(0, 64'd40, 32'hB);
		sync_point();
		start_counter();
		observe(300);
		expect_irq_times(64'd0, 64'd40, 64'd40, 1'b1, 1'b1, 1'b0, 1'b1, 300 - START_WINDOW);
		check_irq(0);
		end_test("Test 3 periodic channel");

		quiet_and_load(64'd0);
		set_channel(1, 64'd50, 32'h3);
		set_channel(2, 64'd30, 32'h9);
		sync_point();
		start_counter();
		observe(200);
		expect_irq_times(64'd0, 64'd50, 64'd50, 1'b0, 1'b1, 1'b0, 1'b1, 200 - START_WINDOW);
		check_irq(1);
		expect_irq_times(64'd0, 64'd30, 64'd30, 1'b1, 1'b0, 1'b0, 1'b1, 200 - START_WINDOW);
		check_irq(2);
		// Rewind the running counter below the spent target
		write_reg(`UTIM_MAIN_LO, 32'd0);
		sync_point();
		issue = tcycle;
		observe(100);
		// A fired one-shot stays disabled
		exp_irq.delete();
		check_irq(1);
		end_test("Test 4 one-shot and masked channels");

		quiet_and_load(64'd0);
		set_channel(3, {32'd1, 32'd60}, 32'h3);
		sync_point();
		start_counter();
		observe(150);
		expect_irq_times(64'd0, {32'd1, 32'd60}, {32'd1, 32'd60}, 1'b0, 1'b1, 1'b0, 1'b1,
			150 - START_WINDOW);
		check_irq(3);
		quiet_and_load(64'd0);
		set_channel(3, {32'd1, 32'd60}, 32'h7);
		sync_point();
		start_counter();
		observe(150);
		expect_irq_times(64'd0, {32'd1, 32'd60}, {32'd1, 32'd60}, 1'b0, 1'b1, 1'b1, 1'b1,
			150 - START_WINDOW);
		check_irq(3);
		// Upper half now matches and the low half decides
		quiet_and_load({32'd1, 32'd0});
		set_channel(3, {32'd1, 32'd60}, 32'h7);
		sync_point();
		start_counter();
		observe(150);
		expect_irq_times({32'd1, 32'd0}, {32'd1, 32'd60}, {32'd1, 32'd60}, 1'b0, 1'b1, 1'b1,
			1'b1, 150 - START_WINDOW);
		check_irq(3);
		end_test("Test 5 32-bit and 64-bit modes");

		quiet_and_load(64'd100);
		set_channel(0, 64'd100, 32'h3);
		sync_point();
		issue = tcycle;
		observe(100);
		expect_irq_times(64'd100, 64'd100, 64'd100, 1'b0, 1'b1, 1'b0, 1'b0, 100 - START_WINDOW);
		check_irq(0);
		end_test("Test 6 stopped counter");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/utim_reg_pkg.sv
logic/utim_timer_pkg.sv
logic/utim_async_fifo.sv
logic/utim_reg_decode.sv
logic/utim_main_counter.sv
logic/utim_comparator.sv
logic/utim_top.sv
dv/utim_tb.sv

// File: logic/utim_async_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "utim_defines.svh"

module utim_async_fifo #(
	parameter int WIDTH = 32
) (
	input logic inRESET,
	input logic wr_clock,
	input logic wr_en,
	input logic [WIDTH-1:0] wr_data,
	output logic wr_full,
	input logic rd_clock,
	input logic rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic rd_empty
);

	localparam int AW = `UTIM_FIFO_DEPTH_LOG2;
	localparam int DEPTH = 1 << AW;

	logic [WIDTH-1:0] mem [DEPTH];

	logic [AW:0] wr_bin;
	logic [AW:0] wr_gray;
	logic [AW:0] wr_bin_next;
	logic [AW:0] rd_bin;
	logic [AW:0] rd_gray;
	logic [AW:0] rd_bin_next;

	// Synchronizer stages
	logic [AW:0] rd_gray_s1;
	logic [AW:0] rd_gray_s2;
	logic [AW:0] wr_gray_s1;
	logic [AW:0] wr_gray_s2;

	logic do_write;
	logic do_read;

	assign do_write = wr_en && !wr_full;
	assign do_read = rd_en && !rd_empty;
	assign wr_bin_next = wr_bin + 1'b1;
	assign rd_bin_next = rd_bin + 1'b1;

	// Write side
	always_ff @(posedge wr_clock or negedge inRESET) begin
		if (!inRESET) begin
			wr_bin <= '0;
			wr_gray <= '0;
		end else if (do_write) begin
			wr_bin <= wr_bin_next;
			wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
		end
	end

	always_ff @(posedge wr_clock) begin
		if (do_write) begin
			mem[wr_bin[AW-1:0]] <= wr_data;
		end
	end

	always_ff @(posedge wr_clock or negedge inRESET) begin
		if (!inRESET) begin
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
		end else begin
			rd_gray_s1 <= rd_gray;
			rd_gray_s2 <= rd_gray_s1;
		end
	end

	// Full when top two Gray bits differ and the rest match
	assign wr_full = (wr_gray == {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]});

	// Read side
	always_ff @(posedge rd_clock or negedge inRESET) begin
		if (!inRESET) begin
			rd_bin <= '0;
			rd_gray <= '0;
		end else if (do_read) begin
			rd_bin <= rd_bin_next;
			rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
		end
	end

	always_ff @(posedge rd_clock or negedge inRESET) begin
		if (!inRESET) begin
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
		end else begin
			wr_gray_s1 <= wr_gray;
			wr_gray_s2 <= wr_gray_s1;
		end
	end

	assign rd_empty = (rd_gray == wr_gray_s2);

	// Head entry, fall-through
	assign rd_data = mem[rd_bin[AW-1:0]];

endmodule

`default_nettype wire

// File: logic/utim_comparator.sv
`timescale 1ns/10ps
`default_nettype none

module utim_comparator (
	input logic iTIMER_CLOCK,
	input logic inRESET,
	input logic counter_running,
	input utim_timer_pkg::count_t counter_value,
	input logic cfg_write,
	input logic lo_write,
	input logic hi_write,
	input utim_reg_pkg::cfg_word_u write_data,
	output logic irq
);

	import utim_reg_pkg::*;
	import utim_timer_pkg::*;

	logic enable;
	logic irq_enable;
	logic mode64;
	logic periodic;

	count_t target;
	count_t period;

	logic match;
	logic fire;

	// 32-bit mode looks at the low halves only
	assign match = mode64 ? (counter_value == target) :
		(counter_value[31:0] == target[31:0]);
	assign fire = enable && counter_running && match;

	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			enable <= 1'b0;
			irq_enable <= 1'b0;
			mode64 <= 1'b0;
			periodic <= 1'b0;
			irq <= 1'b0;
		end else begin
			irq <= fire && irq_enable;
			if (cfg_write) begin
				enable <= write_data.cmp.enable;
				irq_enable <= write_data.cmp.irq_enable;
				mode64 <= write_data.cmp.mode64;
				periodic <= write_data.cmp.periodic;
			end else if (fire && !periodic) begin
				// One-shot
				enable <= 1'b0;
			end
		end
	end

	// Half writes set target and period together
	always_ff @(posedge iTIMER_CLOCK) begin
		if (hi_write) begin
			target[63:32] <= reg_word_t'(write_data);
			period[63:32] <= reg_word_t'(write_data);
		end else if (lo_write) begin
			target[31:0] <= reg_word_t'(write_data);
			period[31:0] <= reg_word_t'(write_data);
		end else if (fire && periodic) begin
			target <= target + period;
		end
	end

endmodule

`default_nettype wire

// File: logic/utim_defines.svh
`ifndef UTIM_DEFINES_SVH
`define UTIM_DEFINES_SVH

// Main counter register addresses
`define UTIM_MAIN_CFG			0
`define UTIM_MAIN_HI			1
`define UTIM_MAIN_LO			2

// Comparator register addresses
// Channel n upper half at HI_BASE + 2n, lower half at LO_BASE + 2n
`define UTIM_CMP_HI_BASE		3
`define UTIM_CMP_LO_BASE		4
`define UTIM_CMP_CFG_BASE		11

// Register file size
`define UTIM_REG_COUNT			15

// FIFO holds 2**N entries
`define UTIM_FIFO_DEPTH_LOG2	2

// Compare channels
`define UTIM_CHANNELS			4

`endif

// File: logic/utim_main_counter.sv
`timescale 1ns/10ps
`default_nettype none

module utim_main_counter (
	input logic iTIMER_CLOCK,
	input logic inRESET,
	input logic cfg_write,
	input logic lo_write,
	input logic hi_write,
	input utim_reg_pkg::cfg_word_u write_data,
	output logic counter_running,
	output utim_timer_pkg::count_t counter_value
);

	import utim_reg_pkg::*;

	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			counter_running <= 1'b0;
		end else if (cfg_write) begin
			counter_running <= write_data.main.enable;
		end
	end

	// Half loads win over counting
	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			counter_value <= '0;
		end else if (hi_write) begin
			counter_value[63:32] <= reg_word_t'(write_data);
		end else if (lo_write) begin
			counter_value[31:0] <= reg_word_t'(write_data);
		end else if (counter_running) begin
			counter_value <= counter_value + 64'd1;
		end
	end

endmodule

`default_nettype wire

// File: logic/utim_reg_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "utim_defines.svh"

module utim_reg_decode (
	input logic iTIMER_CLOCK,
	input logic inRESET,
	input logic req_empty,
	input logic req_rw,
	input utim_reg_pkg::reg_addr_t req_addr,
	input utim_reg_pkg::reg_word_t req_data,
	input logic resp_full,
	output logic req_pop,
	output logic resp_push,
	output utim_reg_pkg::reg_word_t resp_data,
	output logic main_cfg_write,
	output logic main_lo_write,
	output logic main_hi_write,
	output utim_timer_pkg::chan_mask_t cmp_cfg_write,
	output utim_timer_pkg::chan_mask_t cmp_lo_write,
	output utim_timer_pkg::chan_mask_t cmp_hi_write,
	output utim_reg_pkg::cfg_word_u write_data
);

	import utim_reg_pkg::*;
	import utim_timer_pkg::*;

	localparam reg_addr_t HI_BASE = reg_addr_t'(`UTIM_CMP_HI_BASE);
	localparam reg_addr_t LO_BASE = reg_addr_t'(`UTIM_CMP_LO_BASE);
	localparam reg_addr_t CFG_BASE = reg_addr_t'(`UTIM_CMP_CFG_BASE);
	localparam reg_addr_t HI_END = reg_addr_t'(`UTIM_CMP_HI_BASE + 2 * `UTIM_CHANNELS);
	localparam reg_addr_t LO_END = reg_addr_t'(`UTIM_CMP_LO_BASE + 2 * `UTIM_CHANNELS);
	localparam reg_addr_t CFG_END = reg_addr_t'(`UTIM_CMP_CFG_BASE + `UTIM_CHANNELS);

	reg_word_t regs [`UTIM_REG_COUNT];

	logic do_write;
	logic do_read;
	logic addr_valid;
	reg_word_t read_word;

	reg_addr_t hi_off;
	reg_addr_t lo_off;
	chan_idx_t hi_idx;
	chan_idx_t lo_idx;
	chan_idx_t cfg_idx;
	logic hi_sel;
	logic lo_sel;
	logic cfg_sel;

	// Only reads wait for room in the response FIFO
	// A push still in flight holds a slot that resp_full does not show yet
	assign req_pop = !req_empty && (req_rw || (!resp_full && !resp_push));
	assign do_write = req_pop && req_rw;
	assign do_read = req_pop && !req_rw;

	assign addr_valid = (req_addr < reg_addr_t'(`UTIM_REG_COUNT));
	assign read_word = addr_valid ? regs[req_addr] : '0;

	// Channel decode
	assign hi_off = req_addr - HI_BASE;
	assign lo_off = req_addr - LO_BASE;
	assign hi_idx = chan_idx_t'(hi_off >> 1);
	assign lo_idx = chan_idx_t'(lo_off >> 1);
	assign cfg_idx = chan_idx_t'(req_addr - CFG_BASE);
	assign hi_sel = (req_addr >= HI_BASE) && (req_addr < HI_END) && !hi_off[0];
	assign lo_sel = (req_addr >= LO_BASE) && (req_addr < LO_END) && !lo_off[0];
	assign cfg_sel = (req_addr >= CFG_BASE) && (req_addr < CFG_END);

	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < `UTIM_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (do_write && addr_valid) begin
			regs[req_addr] <= req_data;
		end
	end

	// Registered strobes
	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			resp_push <= 1'b0;
			main_cfg_write <= 1'b0;
			main_hi_write <= 1'b0;
			main_lo_write <= 1'b0;
			cmp_hi_write <= '0;
			cmp_lo_write <= '0;
			cmp_cfg_write <= '0;
		end else begin
			resp_push <= do_read;
			main_cfg_write <= do_write && (req_addr == reg_addr_t'(`UTIM_MAIN_CFG));
			main_hi_write <= do_write && (req_addr == reg_addr_t'(`UTIM_MAIN_HI));
			main_lo_write <= do_write && (req_addr == reg_addr_t'(`UTIM_MAIN_LO));
			cmp_hi_write <= (do_write && hi_sel) ? chan_mask_t'(1) << hi_idx : '0;
			cmp_lo_write <= (do_write && lo_sel) ? chan_mask_t'(1) << lo_idx : '0;
			cmp_cfg_write <= (do_write && cfg_sel) ? chan_mask_t'(1) << cfg_idx : '0;
		end
	end

	// Payload
	always_ff @(posedge iTIMER_CLOCK) begin
		write_data <= cfg_word_u'(req_data);
		resp_data <= read_word;
	end

endmodule

`default_nettype wire

// File: logic/utim_reg_pkg.sv
`default_nettype none

package utim_reg_pkg;

	typedef logic [3:0] reg_addr_t;
	typedef logic [31:0] reg_word_t;

	// Request word in the FIFO is {rw, addr, data}
	localparam int REQ_WIDTH = 1 + $bits(reg_addr_t) + $bits(reg_word_t);
	localparam int RESP_WIDTH = $bits(reg_word_t);

	// Main counter configuration word
	typedef struct packed {
		logic [30:0] reserved;
		logic enable;
	} main_cfg_s;

	// Comparator configuration word
	typedef struct packed {
		logic [27:0] reserved;
		logic periodic;
		logic mode64;
		logic irq_enable;
		logic enable;
	} cmp_cfg_s;

	// Same written word, seen by the counter or by a comparator
	typedef union packed {
		main_cfg_s main;
		cmp_cfg_s cmp;
	} cfg_word_u;

endpackage

`default_nettype wire

// File: logic/utim_timer_pkg.sv
`default_nettype none

`include "utim_defines.svh"

package utim_timer_pkg;

	// Counter and compare target
	typedef logic [63:0] count_t;

	// Channel number
	typedef logic [1:0] chan_idx_t;

	// One bit per channel
	typedef logic [`UTIM_CHANNELS-1:0] chan_mask_t;

endpackage

`default_nettype wire

// File: logic/utim_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "utim_defines.svh"

module utim_top (
	input logic iIF_CLOCK,
	input logic iTIMER_CLOCK,
	input logic inRESET,
	input logic req_valid,
	output logic req_busy,
	input logic req_rw,
	input utim_reg_pkg::reg_addr_t req_addr,
	input utim_reg_pkg::reg_word_t req_data,
	output logic resp_valid,
	output utim_reg_pkg::reg_word_t resp_data,
	output utim_timer_pkg::chan_mask_t irq
);

	import utim_reg_pkg::*;
	import utim_timer_pkg::*;

	// Request path
	logic req_empty;
	logic req_pop;
	logic fifo_rw;
	reg_addr_t fifo_addr;
	reg_word_t fifo_data;

	// Response path
	logic resp_full;
	logic resp_empty;
	logic resp_push;
	reg_word_t resp_word;

	// Decode outputs
	logic main_cfg_write;
	logic main_lo_write;
	logic main_hi_write;
	chan_mask_t cmp_cfg_write;
	chan_mask_t cmp_lo_write;
	chan_mask_t cmp_hi_write;
	cfg_word_u write_data;

	logic counter_running;
	count_t counter_value;

	utim_async_fifo #(
		.WIDTH(REQ_WIDTH)
	) u_req_fifo (
		.inRESET(inRESET),
		.wr_clock(iIF_CLOCK),
		.wr_en(req_valid),
		.wr_data({req_rw, req_addr, req_data}),
		.wr_full(req_busy),
		.rd_clock(iTIMER_CLOCK),
		.rd_en(req_pop),
		.rd_data({fifo_rw, fifo_addr, fifo_data}),
		.rd_empty(req_empty)
	);

	utim_reg_decode u_decode (
		.iTIMER_CLOCK(iTIMER_CLOCK),
		.inRESET(inRESET),
		.req_empty(req_empty),
		.req_rw(fifo_rw),
		.req_addr(fifo_addr),
		.req_data(fifo_data),
		.resp_full(resp_full),
		.req_pop(req_pop),
		.resp_push(resp_push),
		.resp_data(resp_word),
		.main_cfg_write(main_cfg_write),
		.main_lo_write(main_lo_write),
		.main_hi_write(main_hi_write),
		.cmp_cfg_write(cmp_cfg_write),
		.cmp_lo_write(cmp_lo_write),
		.cmp_hi_write(cmp_hi_write),
		.write_data(write_data)
	);

	utim_main_counter u_counter (
		.iTIMER_CLOCK(iTIMER_CLOCK),
		.inRESET(inRESET),
		.cfg_write(main_cfg_write),
		.lo_write(main_lo_write),
		.hi_write(main_hi_write),
		.write_data(write_data),
		.counter_running(counter_running),
		.counter_value(counter_value)
	);

	for (genvar i = 0; i < `UTIM_CHANNELS; i++) begin : g_cmp
		utim_comparator u_cmp (
			.iTIMER_CLOCK(iTIMER_CLOCK),
			.inRESET(inRESET),
			.counter_running(counter_running),
			.counter_value(counter_value),
			.cfg_write(cmp_cfg_write[i]),
			.lo_write(cmp_lo_write[i]),
			.hi_write(cmp_hi_write[i]),
			.write_data(write_data),
			.irq(irq[i])
		);
	end

	// Host side pops whenever a response is waiting
	assign resp_valid = !resp_empty;

	utim_async_fifo #(
		.WIDTH(RESP_WIDTH)
	) u_resp_fifo (
		.inRESET(inRESET),
		.wr_clock(iTIMER_CLOCK),
		.wr_en(resp_push),
		.wr_data(resp_word),
		.wr_full(resp_full),
		.rd_clock(iIF_CLOCK),
		.rd_en(resp_valid),
		.rd_data(resp_data),
		.rd_empty(resp_empty)
	);

endmodule

`default_nettype wire
